// ==== src/control_settings.svh ====
`ifndef CONTROL_SETTINGS_SVH
`define CONTROL_SETTINGS_SVH

// Instruction word as held in the instruction register
`define INSTR_WIDTH 32

// Opcode field, bits 6:0
`define OPCODE_WIDTH 7

// funct3 field, bits 14:12
`define FUNCT3_WIDTH 3

// funct7 field, bits 31:25
`define FUNCT7_WIDTH 7

// Nineteen states need five bits
`define STATE_WIDTH 5

// Fifteen instruction classes
`define CLASS_WIDTH 4

`endif

// ==== src/controlPkg.sv ====
`include "control_settings.svh"

package controlPkg;

        typedef enum logic [`OPCODE_WIDTH-1:0] {
                opRegister  = 7'b0110011, // add, sub, and, slt
                opImmediate = 7'b0010011, // addi, slti
                opLoad      = 7'b0000011, // ld only
                opStore     = 7'b0100011, // sd only
                opBranch    = 7'b1100011, // beq, bne, blt, bge
                opJalr      = 7'b1100111,
                opLui       = 7'b0110111,
                opJal       = 7'b1101111,
                opSystem    = 7'b1110011  // ebreak
        } opcodeT;

        typedef enum logic [`CLASS_WIDTH-1:0] {
                aluReg,
                setLessReg,
                addImm,
                setLessImm,
                loadDouble,
                storeDouble,
                branchEq,
                branchNe,
                branchLt,
                branchGe,
                loadUpper,
                jumpLink,
                jumpLinkReg,
                breakpoint,
                unsupported // Back to fetch, no writes
        } instrClassT;

        typedef enum logic [`STATE_WIDTH-1:0] {
                resetState,
                fetch,         // PC + 4
                saveInstr,     // Load IR
                decode,        // Load A and B
                aluExecute,
                compareSetup,  // slt, slti
                setResult,
                writeBack,
                memAddress,
                memRead,
                memCapture,    // Load MDR
                memWriteBack,
                memWrite,
                branchCompare,
                branchTaken,
                linkCapture,   // PC into ALUOut
                linkWrite,
                jumpTarget,
                halted         // ebreak, left only by reset
        } stateT;

        typedef enum logic [2:0] {add, sub, andOp, compare} aluFuncT;

        typedef enum logic [1:0] {srcAPc, srcARegA, srcAZero} aluSrcAT;

        typedef enum logic [2:0] {srcBRegB, srcBFour, srcBImm, srcBZero, srcBOne} aluSrcBT;

        typedef enum logic {memData, aluOut} memToRegT;

        typedef enum logic [2:0] {iType, sType, bType, uType, jType} immFormatT;

        typedef struct packed {
                instrClassT instrClass;
                aluFuncT    aluFunc;   // Used in aluExecute
                immFormatT  immFormat; // To the immediate generator
        } decodedInstrT;

        typedef struct packed {
                logic equal; // ALU operands equal
                logic less;  // Signed A < B
        } condFlagsT;

        typedef struct packed {
                logic     loadIr;
                logic     pcWrite;
                logic     regWrite;
                logic     loadRegA;
                logic     loadRegB;
                logic     loadMdr;
                logic     loadAluOut;
                logic     memWrite;
                aluSrcAT  aluSrcA;
                aluSrcBT  aluSrcB;
                aluFuncT  aluFunc;
                memToRegT memToReg;
        } controlWordT;

endpackage

// ==== src/instrDecoder.sv ====
`timescale 1ns/1ps
`include "control_settings.svh"

module instrDecoder import controlPkg::*; (
        input  logic [`INSTR_WIDTH-1:0] instruction,
        output decodedInstrT            decoded
);

        opcodeT                   opcode;
        logic [`FUNCT3_WIDTH-1:0] funct3;
        logic [`FUNCT7_WIDTH-1:0] funct7;
        logic                     isEbreak;

        assign opcode   = opcodeT'(instruction[`OPCODE_WIDTH-1:0]);
        assign funct3   = instruction[14:12];
        assign funct7   = instruction[31:25];
        assign isEbreak = (instruction[31:20] == 12'd1) && (instruction[19:7] == '0); // imm 1

        always_comb begin
                decoded.instrClass = unsupported; // Anything unmatched
                decoded.aluFunc    = add;
                decoded.immFormat  = iType;
                case (opcode)
                        opRegister: begin
                                case ({funct7, funct3})
                                        10'b0000000_000: decoded.instrClass = aluReg;
                                        10'b0100000_000: begin
                                                decoded.instrClass = aluReg;
                                                decoded.aluFunc    = sub;
                                        end
                                        10'b0000000_111: begin
                                                decoded.instrClass = aluReg;
                                                decoded.aluFunc    = andOp;
                                        end
                                        10'b0000000_010: begin
                                                decoded.instrClass = setLessReg;
                                                decoded.aluFunc    = compare;
                                        end
                                        default: decoded.instrClass = unsupported;
                                endcase
                        end
                        opImmediate: begin
                                if (funct3 == 3'b000) begin
                                        decoded.instrClass = addImm;
                                end else if (funct3 == 3'b010) begin
                                        decoded.instrClass = setLessImm;
                                        decoded.aluFunc    = compare;
                                end
                        end
                        opLoad: begin
                                if (funct3 == 3'b011) decoded.instrClass = loadDouble; // ld
                        end
                        opStore: begin
                                decoded.immFormat = sType;
                                if (funct3 == 3'b011) decoded.instrClass = storeDouble; // sd
                        end
                        opBranch: begin
                                decoded.immFormat = bType;
                                case (funct3)
                                        3'b000:  decoded.instrClass = branchEq;
                                        3'b001:  decoded.instrClass = branchNe;
                                        3'b100:  decoded.instrClass = branchLt;
                                        3'b101:  decoded.instrClass = branchGe;
                                        default: decoded.instrClass = unsupported;
                                endcase
                        end
                        opJalr: begin
                                if (funct3 == 3'b000) decoded.instrClass = jumpLinkReg;
                        end
                        opLui: begin
                                decoded.instrClass = loadUpper; // Zero plus immediate
                                decoded.immFormat  = uType;
                        end
                        opJal: begin
                                decoded.instrClass = jumpLink;
                                decoded.immFormat  = jType;
                        end
                        opSystem: begin
                                if (isEbreak) decoded.instrClass = breakpoint; // ecall not kept
                        end
                        default: decoded.instrClass = unsupported;
                endcase
        end

endmodule

// ==== src/controlSequencer.sv ====
`timescale 1ns/1ps

module controlSequencer import controlPkg::*; (
        input  logic         clock,
        input  logic         reset,
        input  decodedInstrT decoded,
        input  condFlagsT    flags,
        output stateT        state
);

        stateT nextState;
        logic  takeBranch;

        // Branch condition, only looked at in branchCompare
        always_comb begin
                case (decoded.instrClass)
                        branchEq: takeBranch = flags.equal;
                        branchNe: takeBranch = !flags.equal;
                        branchLt: takeBranch = flags.less;
                        branchGe: takeBranch = !flags.less; // Not less means >=
                        default:  takeBranch = 1'b0;
                endcase
        end

        always_ff @(posedge clock, posedge reset) begin
                if (reset) begin
                        state <= resetState;
                end else begin
                        state <= nextState;
                end
        end

        always_comb begin
                nextState = fetch; // Most paths end here
                case (state)
                        resetState: nextState = fetch;
                        fetch:      nextState = saveInstr;
                        saveInstr:  nextState = decode;
                        decode: begin
                                case (decoded.instrClass)
                                        aluReg, addImm, loadUpper:
                                                nextState = aluExecute;
                                        setLessReg, setLessImm:
                                                nextState = compareSetup;
                                        loadDouble, storeDouble:
                                                nextState = memAddress;
                                        branchEq, branchNe, branchLt, branchGe:
                                                nextState = branchCompare;
                                        jumpLink, jumpLinkReg:
                                                nextState = linkCapture;
                                        breakpoint:
                                                nextState = halted;
                                        default:
                                                nextState = fetch; // Unsupported, no write
                                endcase
                        end
                        aluExecute:   nextState = writeBack;
                        compareSetup: nextState = setResult;
                        setResult:    nextState = writeBack;
                        writeBack:    nextState = fetch;
                        memAddress: begin
                                if (decoded.instrClass == loadDouble) begin
                                        nextState = memRead;
                                end else begin
                                        nextState = memWrite; // sd
                                end
                        end
                        memRead:      nextState = memCapture;
                        memCapture:   nextState = memWriteBack;
                        memWriteBack: nextState = fetch;
                        memWrite:     nextState = fetch;
                        branchCompare: begin
                                if (takeBranch) begin
                                        nextState = branchTaken;
                                end else begin
                                        nextState = fetch; // Fall through
                                end
                        end
                        branchTaken:  nextState = fetch;
                        linkCapture:  nextState = linkWrite;
                        linkWrite:    nextState = jumpTarget;
                        jumpTarget:   nextState = fetch;
                        halted:       nextState = halted; // Until reset
                        default:      nextState = fetch;
                endcase
        end

endmodule

// ==== src/controlWordGen.sv ====
`timescale 1ns/1ps

module controlWordGen import controlPkg::*; (
        input  stateT        state,
        input  decodedInstrT decoded,
        input  condFlagsT    flags,
        output controlWordT  control
);

        always_comb begin
                control          = '0;       // No loads, no writes
                control.aluSrcA  = srcAZero;
                control.aluSrcB  = srcBZero;
                control.aluFunc  = add;
                control.memToReg = memData;
                case (state)
                        fetch: begin
                                control.pcWrite = 1'b1; // PC + 4
                                control.aluSrcA = srcAPc;
                                control.aluSrcB = srcBFour;
                        end
                        saveInstr: control.loadIr = 1'b1;
                        decode: begin
                                control.loadRegA = 1'b1; // rs1
                                control.loadRegB = 1'b1; // rs2
                        end
                        aluExecute: begin
                                control.loadAluOut = 1'b1;
                                control.aluFunc    = decoded.aluFunc;
                                case (decoded.instrClass)
                                        addImm: begin
                                                control.aluSrcA = srcARegA;
                                                control.aluSrcB = srcBImm;
                                        end
                                        loadUpper: control.aluSrcB = srcBImm; // Zero plus imm
                                        default: begin
                                                control.aluSrcA = srcARegA;
                                                control.aluSrcB = srcBRegB;
                                        end
                                endcase
                        end
                        compareSetup: begin
                                control.aluFunc = compare;
                                control.aluSrcA = srcARegA;
                                if (decoded.instrClass == setLessImm) begin
                                        control.aluSrcB = srcBImm;
                                end else begin
                                        control.aluSrcB = srcBRegB;
                                end
                        end
                        setResult: begin
                                control.loadAluOut = 1'b1; // Zero plus one or zero
                                if (flags.less) control.aluSrcB = srcBOne;
                        end
                        writeBack, linkWrite: begin
                                control.regWrite = 1'b1;
                                control.memToReg = aluOut;
                        end
                        memAddress: begin
                                control.loadAluOut = 1'b1; // rs1 + offset
                                control.aluSrcA    = srcARegA;
                                control.aluSrcB    = srcBImm;
                        end
                        memCapture:   control.loadMdr  = 1'b1;
                        memWriteBack: control.regWrite = 1'b1; // MDR to rd
                        memWrite:     control.memWrite = 1'b1; // B at ALUOut
                        branchCompare: begin
                                control.aluFunc = compare;
                                control.aluSrcA = srcARegA;
                                control.aluSrcB = srcBRegB;
                        end
                        branchTaken: begin
                                control.pcWrite = 1'b1;
                                control.aluSrcA = srcAPc;
                                control.aluSrcB = srcBImm;
                        end
                        linkCapture: begin
                                control.loadAluOut = 1'b1; // Return address
                                control.aluSrcA    = srcAPc;
                        end
                        jumpTarget: begin
                                control.pcWrite = 1'b1;
                                control.aluSrcB = srcBImm;
                                if (decoded.instrClass == jumpLinkReg) begin
                                        control.aluSrcA = srcARegA;
                                end else begin
                                        control.aluSrcA = srcAPc;
                                end
                        end
                        default: control.pcWrite = 1'b0; // resetState, memRead, halted
                endcase
        end

endmodule

// ==== src/multicycleControl.sv ====
`timescale 1ns/1ps
`include "control_settings.svh"

module multicycleControl import controlPkg::*; (
        input  logic                    clock,
        input  logic                    reset,
        input  logic [`INSTR_WIDTH-1:0] instruction, // IR output
        input  condFlagsT               flags,
        output controlWordT             control,
        output immFormatT               immFormat
);

        decodedInstrT decoded;
        stateT        state;

        assign immFormat = decoded.immFormat; // To immediate generator

        instrDecoder u_decoder (
                .instruction (instruction),
                .decoded     (decoded)
        );

        controlSequencer u_sequencer (
                .clock   (clock),
                .reset   (reset),
                .decoded (decoded),
                .flags   (flags),
                .state   (state)
        );

        controlWordGen u_wordGen (
                .state   (state),
                .decoded (decoded),
                .flags   (flags),
                .control (control)
        );

endmodule

// ==== bench/benchChecks.svh ====
`ifndef BENCH_CHECKS_SVH
`define BENCH_CHECKS_SVH

int controlErrors = 0; // Wrong control words
int formatErrors  = 0; // Wrong immediate formats

// Whole word compared at once, fields shown in hex
task automatic checkControl(input controlWordT actual, input controlWordT expected,
                input string where);
        if (actual !== expected) begin
                controlErrors = controlErrors + 1;
                $display("CHECK FAILED control in %s at %0t: got %h expected %h",
                        where, $time, actual, expected);
                $display("  got loads %b%b%b%b%b%b%b%b srcA %h srcB %h func %h toReg %h",
                        actual.loadIr, actual.pcWrite, actual.regWrite, actual.loadRegA,
                        actual.loadRegB, actual.loadMdr, actual.loadAluOut, actual.memWrite,
                        actual.aluSrcA, actual.aluSrcB, actual.aluFunc, actual.memToReg);
        end
endtask

// Format seen by the immediate generator
task automatic checkImmFormat(input immFormatT actual, input immFormatT expected,
                input string where);
        if (actual !== expected) begin
                formatErrors = formatErrors + 1;
                $display("CHECK FAILED immFormat in %s at %0t: got %h expected %h",
                        where, $time, actual, expected);
        end
endtask

`endif

// ==== bench/controlBench.sv ====
`timescale 1ns/1ps
`include "control_settings.svh"

module controlBench import controlPkg::*; ();

        localparam int clockPeriod  = 8;
        localparam int resetCycles  = 10;
        localparam int testCycles   = 159; // All tests, both resets included
        localparam int marginCycles = 200;

        // Load and write bits, in struct order
        localparam logic [7:0] noBits    = 8'h00;
        localparam logic [7:0] irBit     = 8'h80;
        localparam logic [7:0] pcBit     = 8'h40;
        localparam logic [7:0] regBit    = 8'h20;
        localparam logic [7:0] abBits    = 8'h18; // loadRegA and loadRegB
        localparam logic [7:0] mdrBit    = 8'h04;
        localparam logic [7:0] aluOutBit = 8'h02;
        localparam logic [7:0] memBit    = 8'h01;

        logic                    clock;
        logic                    reset;
        logic [`INSTR_WIDTH-1:0] instruction;
        condFlagsT               flags;
        controlWordT             control;
        immFormatT               immFormat;
        logic [31:0]             lfsrState; // Operand field source

        `include "benchChecks.svh"

        multicycleControl u_dut (
                .clock       (clock),
                .reset       (reset),
                .instruction (instruction),
                .flags       (flags),
                .control     (control),
                .immFormat   (immFormat)
        );

        initial begin
                clock = 1'b0;
                forever #(clockPeriod / 2) clock = ~clock;
        end

        initial begin
                #((testCycles + marginCycles) * clockPeriod);
                $display("Timeout: the control unit never got through all the tests");
                $display("Result: FAILED");
                $finish;
        end

        // Galois LFSR, one step per bit
        function automatic logic [31:0] nextBits(input int count);
                logic [31:0] value;
                logic        outBit;
                value = '0;
                for (int i = 0; i < count; i++) begin
                        outBit    = lfsrState[0];
                        lfsrState = lfsrState >> 1;
                        if (outBit) lfsrState = lfsrState ^ 32'hD000_0001;
                        value = {value[30:0], outBit};
                end
                return value;
        endfunction

        function automatic controlWordT makeWord(input logic [7:0] bits, input aluSrcAT srcA,
                        input aluSrcBT srcB, input aluFuncT func, input memToRegT toReg);
                controlWordT word;
                word.loadIr     = bits[7];
                word.pcWrite    = bits[6];
                word.regWrite   = bits[5];
                word.loadRegA   = bits[4];
                word.loadRegB   = bits[3];
                word.loadMdr    = bits[2];
                word.loadAluOut = bits[1];
                word.memWrite   = bits[0];
                word.aluSrcA    = srcA;
                word.aluSrcB    = srcB;
                word.aluFunc    = func;
                word.memToReg   = toReg;
                return word;
        endfunction

        function automatic controlWordT idleWord();
                return makeWord(noBits, srcAZero, srcBZero, add, memData); // Nothing loads
        endfunction

        // R-type, random rs1, rs2, rd
        function automatic logic [31:0] regInstr(input logic [6:0] funct7,
                        input logic [2:0] funct3);
                logic [4:0] rs1;
                logic [4:0] rs2;
                logic [4:0] rd;
                rs1 = 5'(nextBits(5));
                rs2 = 5'(nextBits(5));
                rd  = 5'(nextBits(5));
                return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
        endfunction

        // I-type layout, also bits of S and B
        function automatic logic [31:0] immInstr(input logic [2:0] funct3,
                        input logic [6:0] opcode);
                logic [11:0] imm;
                logic [4:0]  rs1;
                logic [4:0]  rd;
                imm = 12'(nextBits(12));
                rs1 = 5'(nextBits(5));
                rd  = 5'(nextBits(5));
                return {imm, rs1, funct3, rd, opcode};
        endfunction

        function automatic logic [31:0] upperInstr(input logic [6:0] opcode);
                return {20'(nextBits(20)), 5'(nextBits(5)), opcode}; // lui, jal
        endfunction

        task automatic applyReset();
                reset = 1'b1;
                repeat (resetCycles) @(posedge clock);
                #1 reset = 1'b0;
        endtask

        // Sample mid-cycle, then step to the next drive point
        task automatic expectWord(input controlWordT expected, input immFormatT fmt,
                        input string where);
                #2;
                checkControl(control, expected, where);
                checkImmFormat(immFormat, fmt, where);
                @(posedge clock);
                #1;
        endtask

        // Called at the drive point of a fetch cycle
        task automatic startInstr(input logic [31:0] instr, input logic eq, input logic lt,
                        input immFormatT fmt);
                instruction = instr;
                flags.equal = eq;
                flags.less  = lt;
                expectWord(makeWord(pcBit, srcAPc, srcBFour, add, memData), fmt, "fetch");
                expectWord(makeWord(irBit, srcAZero, srcBZero, add, memData), fmt, "saveInstr");
                expectWord(makeWord(abBits, srcAZero, srcBZero, add, memData), fmt, "decode");
        endtask

        task automatic runAluReg(input logic [6:0] funct7, input logic [2:0] funct3,
                        input aluFuncT func);
                startInstr(regInstr(funct7, funct3), 1'b0, 1'b0, iType);
                expectWord(makeWord(aluOutBit, srcARegA, srcBRegB, func, memData), iType,
                        "aluExecute");
                expectWord(makeWord(regBit, srcAZero, srcBZero, add, aluOut), iType, "writeBack");
        endtask

        // addi is regA plus imm, lui is zero plus imm
        task automatic runAluImm(input logic isLui);
                aluSrcAT   srcA;
                immFormatT fmt;
                if (isLui) begin
                        srcA = srcAZero;
                        fmt  = uType;
                        startInstr(upperInstr(7'b0110111), 1'b0, 1'b0, fmt);
                end else begin
                        srcA = srcARegA;
                        fmt  = iType;
                        startInstr(immInstr(3'b000, 7'b0010011), 1'b0, 1'b0, fmt);
                end
                expectWord(makeWord(aluOutBit, srcA, srcBImm, add, memData), fmt, "aluExecute");
                expectWord(makeWord(regBit, srcAZero, srcBZero, add, aluOut), fmt, "writeBack");
        endtask

        task automatic runSetLess(input logic useImm, input logic lessFlag);
                aluSrcBT compareB;
                aluSrcBT resultB;
                logic    eq;
                eq = 1'(nextBits(1)); // Equal flag plays no part here
                if (useImm) begin
                        compareB = srcBImm;
                        startInstr(immInstr(3'b010, 7'b0010011), eq, lessFlag, iType);
                end else begin
                        compareB = srcBRegB;
                        startInstr(regInstr(7'b0000000, 3'b010), eq, lessFlag, iType);
                end
                if (lessFlag) resultB = srcBOne;
                else resultB = srcBZero;
                expectWord(makeWord(noBits, srcARegA, compareB, compare, memData), iType,
                        "compareSetup");
                expectWord(makeWord(aluOutBit, srcAZero, resultB, add, memData), iType,
                        "setResult");
                expectWord(makeWord(regBit, srcAZero, srcBZero, add, aluOut), iType, "writeBack");
        endtask

        task automatic runLoad();
                startInstr(immInstr(3'b011, 7'b0000011), 1'b0, 1'b0, iType);
                expectWord(makeWord(aluOutBit, srcARegA, srcBImm, add, memData), iType,
                        "memAddress");
                expectWord(idleWord(), iType, "memRead");
                expectWord(makeWord(mdrBit, srcAZero, srcBZero, add, memData), iType,
                        "memCapture");
                expectWord(makeWord(regBit, srcAZero, srcBZero, add, memData), iType,
                        "memWriteBack");
        endtask

        task automatic runStore();
                startInstr(immInstr(3'b011, 7'b0100011), 1'b0, 1'b0, sType); // sd
                expectWord(makeWord(aluOutBit, srcARegA, srcBImm, add, memData), sType,
                        "memAddress");
                expectWord(makeWord(memBit, srcAZero, srcBZero, add, memData), sType, "memWrite");
        endtask

        task automatic runBranch(input logic [2:0] funct3, input logic eq, input logic lt,
                        input logic taken);
                startInstr(immInstr(funct3, 7'b1100011), eq, lt, bType);
                expectWord(makeWord(noBits, srcARegA, srcBRegB, compare, memData), bType,
                        "branchCompare");
                if (taken) begin
                        expectWord(makeWord(pcBit, srcAPc, srcBImm, add, memData), bType,
                                "branchTaken");
                end
        endtask

        task automatic runJump(input logic viaReg);
                aluSrcAT   base;
                immFormatT fmt;
                if (viaReg) begin
                        base = srcARegA;
                        fmt  = iType;
                        startInstr(immInstr(3'b000, 7'b1100111), 1'b0, 1'b0, fmt); // jalr
                end else begin
                        base = srcAPc;
                        fmt  = jType;
                        startInstr(upperInstr(7'b1101111), 1'b0, 1'b0, fmt); // jal
                end
                expectWord(makeWord(aluOutBit, srcAPc, srcBZero, add, memData), fmt,
                        "linkCapture");
                expectWord(makeWord(regBit, srcAZero, srcBZero, add, aluOut), fmt, "linkWrite");
                expectWord(makeWord(pcBit, base, srcBImm, add, memData), fmt, "jumpTarget");
        endtask

        // Custom-0 opcode, then straight back to fetch
        task automatic runUnsupported();
                startInstr({25'(nextBits(25)), 7'b0001011}, 1'b0, 1'b0, iType);
        endtask

        task automatic runBreakpoint();
                startInstr(32'h0010_0073, 1'b0, 1'b0, iType);
                repeat (20) expectWord(idleWord(), iType, "halted");
                applyReset(); // Only way out
                expectWord(idleWord(), iType, "resetState");
                expectWord(makeWord(pcBit, srcAPc, srcBFour, add, memData), iType, "fetch");
        endtask

        initial begin
                reset       = 1'b1;
                instruction = '0;
                flags       = '0;
                lfsrState   = 32'h4c0b_f14a;
                applyReset();
                expectWord(idleWord(), iType, "resetState"); // One cycle before fetch
                runAluReg(7'b0000000, 3'b000, add);
                runAluReg(7'b0100000, 3'b000, sub);
                runAluReg(7'b0000000, 3'b111, andOp);
                runAluImm(1'b0);
                runAluImm(1'b1);
                runSetLess(1'b0, 1'b1);
                runSetLess(1'b0, 1'b0);
                runSetLess(1'b1, 1'b1);
                runSetLess(1'b1, 1'b0);
                runLoad();
                runStore();
                runBranch(3'b000, 1'b1, 1'b1, 1'b1); // beq, less held
                runBranch(3'b000, 1'b0, 1'b1, 1'b0);
                runBranch(3'b001, 1'b0, 1'b1, 1'b1); // bne, less held
                runBranch(3'b001, 1'b1, 1'b1, 1'b0);
                runBranch(3'b100, 1'b1, 1'b1, 1'b1); // blt, equal held
                runBranch(3'b100, 1'b1, 1'b0, 1'b0);
                runBranch(3'b101, 1'b0, 1'b0, 1'b1); // bge, equal held
                runBranch(3'b101, 1'b0, 1'b1, 1'b0);
                runJump(1'b0);
                runJump(1'b1);
                runUnsupported();
                runBreakpoint();
                $display("Errors: control %0d, immFormat %0d", controlErrors, formatErrors);
                if (controlErrors + formatErrors == 0) begin
                        $display("Result: PASSED");
                end else begin
                        $display("Result: FAILED");
                end
                $finish;
        end

endmodule

// ==== src.f ====
+incdir+src
+incdir+bench
src/controlPkg.sv
src/instrDecoder.sv
src/controlSequencer.sv
src/controlWordGen.sv
src/multicycleControl.sv
bench/controlBench.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -f src.f \
        --top-module controlBench -o controlSim

./obj_dir/controlSim | tee sim.log

if grep -qx "Result: PASSED" sim.log; then
        echo "Simulation passed"
else
        echo "Simulation failed"
        exit 1
fi
